//--- files.f
hdl/decode_pkg.sv
hdl/instr_queue.sv
hdl/ctrl_decoder.sv
hdl/ctrl_issue.sv
hdl/decode_unit.sv
sim/tb_decode_unit.sv

//--- hdl/ctrl_decoder.sv
module ctrl_decoder import decode_pkg::*; #(
    parameter int ENABLE_HW_MULT = 1,
    parameter int ENABLE_HW_DIV  = 1
) (
    input  instr_u head,                         // Instruction at queue head
    output ctrl_t  ctrl_next                     // Decoded control word
);

    logic known_op;                              // Encoding is in the table

    // ------------------------------------------------------------------------
    // Decode table
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl_next = '0;
        known_op  = 1'b1;

        case (head.r.opcode)
            OP_SPECIAL: begin
                case (head.r.funct)
                    FN_ADD:   ctrl_next.alu_op = ALU_ADD;
                    FN_ADDU:  ctrl_next.alu_op = ALU_ADDU;
                    FN_SUB:   ctrl_next.alu_op = ALU_SUB;
                    FN_SUBU:  ctrl_next.alu_op = ALU_SUBU;
                    FN_AND:   ctrl_next.alu_op = ALU_AND;
                    FN_OR:    ctrl_next.alu_op = ALU_OR;
                    FN_XOR:   ctrl_next.alu_op = ALU_XOR;
                    FN_NOR:   ctrl_next.alu_op = ALU_NOR;
                    FN_SLT:   ctrl_next.alu_op = ALU_SLT;
                    FN_SLTU:  ctrl_next.alu_op = ALU_SLTU;
                    FN_SLL:   ctrl_next.alu_op = ALU_SLL;
                    FN_SRL:   ctrl_next.alu_op = ALU_SRL;
                    FN_SRA:   ctrl_next.alu_op = ALU_SRA;
                    FN_SLLV:  ctrl_next.alu_op = ALU_SLL;   // Amount from rs
                    FN_SRLV:  ctrl_next.alu_op = ALU_SRL;
                    FN_SRAV:  ctrl_next.alu_op = ALU_SRA;
                    FN_MULT:  ctrl_next.alu_op = ALU_MULT;
                    FN_MULTU: ctrl_next.alu_op = ALU_MULTU;
                    FN_DIV:   ctrl_next.alu_op = ALU_DIV;
                    FN_DIVU:  ctrl_next.alu_op = ALU_DIVU;
                    FN_MFHI:  ctrl_next.alu_op = ALU_MFHI;
                    FN_MFLO:  ctrl_next.alu_op = ALU_MFLO;
                    FN_MTHI:  ctrl_next.alu_op = ALU_MTHI;
                    FN_MTLO:  ctrl_next.alu_op = ALU_MTLO;
                    FN_JR:    ctrl_next.jump   = 1'b1;      // Target from rs
                    FN_JALR: begin
                        ctrl_next.jump       = 1'b1;
                        ctrl_next.alu_op     = ALU_ADDU;    // Link = PC + 4
                        ctrl_next.port_a_sel = A_PC;
                        ctrl_next.port_b_sel = B_PC_ADD4;
                    end
                    default:  known_op = 1'b0;
                endcase
                // Everything writes rd except HI/LO sources and JR
                ctrl_next.gpr_we = !(head.r.funct inside {FN_MULT, FN_MULTU, FN_DIV,
                                                          FN_DIVU, FN_MTHI, FN_MTLO, FN_JR});
                if (head.r.funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
                    ctrl_next.port_a_sel = A_SHAMT;
                end
            end
            OP_REGIMM: begin
                ctrl_next.branch = 1'b1;         // Condition comes from rt field
                ctrl_next.alu_op = ALU_SUB;
                if (!(head.i.rt inside {RI_BLTZ, RI_BGEZ})) begin
                    known_op = 1'b0;
                end
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                ctrl_next.branch = 1'b1;
                ctrl_next.alu_op = ALU_SUB;      // Compare rs against rt
            end
            OP_J:     ctrl_next.jump = 1'b1;
            OP_JAL: begin
                ctrl_next.jump       = 1'b1;
                ctrl_next.gpr_we     = 1'b1;
                ctrl_next.wa_sel     = WA_R31;
                ctrl_next.alu_op     = ALU_ADDU;
                ctrl_next.port_a_sel = A_PC;
                ctrl_next.port_b_sel = B_PC_ADD4;
            end
            OP_ADDI:  ctrl_next.alu_op = ALU_ADD;
            OP_ADDIU: ctrl_next.alu_op = ALU_ADDU;
            OP_SLTI:  ctrl_next.alu_op = ALU_SLT;
            OP_SLTIU: ctrl_next.alu_op = ALU_SLTU;
            OP_ANDI:  ctrl_next.alu_op = ALU_AND;
            OP_ORI:   ctrl_next.alu_op = ALU_OR;
            OP_XORI:  ctrl_next.alu_op = ALU_XOR;
            OP_LUI:   ctrl_next.alu_op = ALU_LUI;
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW: begin
                ctrl_next.alu_op = ALU_ADDU;     // Address = rs + simm
            end
            default:  known_op = 1'b0;
        endcase

        // --------------------------------------------------------------------
        // Group attributes of the I-type encodings
        // --------------------------------------------------------------------
        if (head.i.opcode inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                  OP_XORI, OP_LUI}) begin
            ctrl_next.gpr_we     = 1'b1;
            ctrl_next.wa_sel     = WA_RT;
            ctrl_next.port_b_sel = (head.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI}) ?
                                   B_ZIMM : B_SIMM;
        end
        if (head.i.opcode inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) begin
            ctrl_next.gpr_we     = 1'b1;
            ctrl_next.mem_to_gpr = 1'b1;
            ctrl_next.wa_sel     = WA_RT;
        end
        if (head.i.opcode inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
                                  OP_SB, OP_SH, OP_SW}) begin
            ctrl_next.port_b_sel   = B_SIMM;
            ctrl_next.mem_write    = head.i.opcode inside {OP_SB, OP_SH, OP_SW};
            ctrl_next.mem_byte     = head.i.opcode inside {OP_LB, OP_LBU, OP_SB};
            ctrl_next.mem_halfword = head.i.opcode inside {OP_LH, OP_LHU, OP_SH};
            ctrl_next.mem_sign_ext = head.i.opcode inside {OP_LB, OP_LH};
        end
        ctrl_next.imm_sign_ext = !(head.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI});

        if (!known_op) begin
            ctrl_next = '0;                      // Unknown gives an empty word
        end

        // --------------------------------------------------------------------
        // Reserved check for missing arithmetic units
        // --------------------------------------------------------------------
        if (ENABLE_HW_MULT == 0 && ctrl_next.alu_op inside {ALU_MULT, ALU_MULTU, ALU_MFHI,
                                                             ALU_MFLO, ALU_MTHI, ALU_MTLO}) begin
            ctrl_next.reserved = 1'b1;           // Other fields kept as decoded
        end
        if (ENABLE_HW_DIV == 0 && ctrl_next.alu_op inside {ALU_DIV, ALU_DIVU}) begin
            ctrl_next.reserved = 1'b1;
        end
    end

endmodule

//--- hdl/ctrl_issue.sv
module ctrl_issue import decode_pkg::*; #(
    parameter int OUT_CREDITS = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  not_empty,                     // Queue has a head entry
    input  ctrl_t ctrl_next,                     // Decoded head
    input  logic  ctrl_credit,                   // Credit back from execute
    output logic  pop,
    output logic  ctrl_valid,
    output ctrl_t ctrl
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credits;                   // Slots free on execute side

    // Issue whenever there is a word and somewhere to put it
    assign pop = not_empty && (credits != '0);

    // ------------------------------------------------------------------------
    // Credit counter and valid flag
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits    <= CNT_W'(OUT_CREDITS);
            ctrl_valid <= 1'b0;
        end else begin
            credits    <= credits - CNT_W'(pop) + CNT_W'(ctrl_credit);
            ctrl_valid <= pop;                   // Word visible one cycle after pop
        end
    end

    // Control word register, loaded only on issue
    always_ff @(posedge clk) begin
        if (pop) begin
            ctrl <= ctrl_next;
        end
    end

    // Execute must not return more credits than it was given
    assert property (@(posedge clk) disable iff (!rst_n)
                     credits <= CNT_W'(OUT_CREDITS))
        else $error("ctrl_issue: credit overflow, count %0d", credits);

endmodule

//--- hdl/decode_pkg.sv
package decode_pkg;

    // ------------------------------------------------------------------------
    // Instruction encodings
    // ------------------------------------------------------------------------
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,                      // R-type, decoded on funct
        OP_REGIMM  = 6'h01,                      // Decoded on rt
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,                      // Zero-extended imm
        OP_ORI     = 6'h0d,                      // Zero-extended imm
        OP_XORI    = 6'h0e,                      // Zero-extended imm
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL   = 6'h00, FN_SRL   = 6'h02, FN_SRA   = 6'h03,   // Shift by shamt
        FN_SLLV  = 6'h04, FN_SRLV  = 6'h06, FN_SRAV  = 6'h07,   // Shift by rs
        FN_JR    = 6'h08, FN_JALR  = 6'h09,
        FN_MFHI  = 6'h10, FN_MTHI  = 6'h11, FN_MFLO  = 6'h12, FN_MTLO  = 6'h13,
        FN_MULT  = 6'h18, FN_MULTU = 6'h19, FN_DIV   = 6'h1a, FN_DIVU  = 6'h1b,
        FN_ADD   = 6'h20, FN_ADDU  = 6'h21, FN_SUB   = 6'h22, FN_SUBU  = 6'h23,
        FN_AND   = 6'h24, FN_OR    = 6'h25, FN_XOR   = 6'h26, FN_NOR   = 6'h27,
        FN_SLT   = 6'h2a, FN_SLTU  = 6'h2b
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ = 5'h00,
        RI_BGEZ = 5'h01
    } regimm_e;

    // ------------------------------------------------------------------------
    // Datapath selectors
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        ALU_NONE  = 5'd0,                        // Also the unknown-op value
        ALU_ADD   = 5'd1,
        ALU_ADDU  = 5'd2,
        ALU_SUB   = 5'd3,
        ALU_SUBU  = 5'd4,
        ALU_AND   = 5'd5,
        ALU_OR    = 5'd6,
        ALU_XOR   = 5'd7,
        ALU_NOR   = 5'd8,
        ALU_SLT   = 5'd9,
        ALU_SLTU  = 5'd10,
        ALU_SLL   = 5'd11,
        ALU_SRL   = 5'd12,
        ALU_SRA   = 5'd13,
        ALU_LUI   = 5'd14,
        ALU_MULT  = 5'd15,                       // Multiplier group from here
        ALU_MULTU = 5'd16,
        ALU_DIV   = 5'd17,                       // Divider group
        ALU_DIVU  = 5'd18,
        ALU_MFHI  = 5'd19,
        ALU_MFLO  = 5'd20,
        ALU_MTHI  = 5'd21,
        ALU_MTLO  = 5'd22
    } alu_op_e;

    typedef enum logic [1:0] {
        A_RS    = 2'd0,
        A_SHAMT = 2'd1,                          // Immediate shifts
        A_PC    = 2'd2                           // Link address
    } port_a_sel_e;

    typedef enum logic [1:0] {
        B_RT      = 2'd0,
        B_SIMM    = 2'd1,
        B_PC_ADD4 = 2'd2,
        B_ZIMM    = 2'd3
    } port_b_sel_e;

    typedef enum logic [1:0] {
        WA_RD  = 2'd0,
        WA_RT  = 2'd1,
        WA_R31 = 2'd2                            // Link register
    } wa_sel_e;

    // ------------------------------------------------------------------------
    // Instruction word, read as R or I fields
    // ------------------------------------------------------------------------
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;                         // Branch condition for REGIMM
        logic [15:0] imm16;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    // Decoded control word, all flags active high
    typedef struct packed {
        alu_op_e     alu_op;
        port_a_sel_e port_a_sel;
        port_b_sel_e port_b_sel;
        wa_sel_e     wa_sel;
        logic        gpr_we;                     // GPR write enable
        logic        mem_to_gpr;                 // Write-back from memory
        logic        jump;
        logic        branch;
        logic        mem_write;
        logic        mem_byte;
        logic        mem_halfword;
        logic        mem_sign_ext;               // Sign-extend loaded data
        logic        imm_sign_ext;               // Sign-extend imm16
        logic        reserved;                   // Reserved instruction
    } ctrl_t;

endpackage

//--- hdl/decode_unit.sv
module decode_unit import decode_pkg::*; #(
    parameter int QUEUE_DEPTH    = 4,            // Also the initial fetch credits
    parameter int OUT_CREDITS    = 2,            // Initial execute credits
    parameter int ENABLE_HW_MULT = 1,
    parameter int ENABLE_HW_DIV  = 1
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   instr_valid,
    input  instr_u instr,
    output logic   instr_credit,
    output logic   ctrl_valid,
    output ctrl_t  ctrl,
    input  logic   ctrl_credit
);

    instr_u head;                                // Queue head to decoder
    logic   not_empty;
    logic   pop;
    ctrl_t  ctrl_next;                           // Combinational decode

    instr_queue #(
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) instr_queue_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .pop            (pop),
        .head           (head),
        .not_empty      (not_empty),
        .instr_credit   (instr_credit)
    );

    ctrl_decoder #(
        .ENABLE_HW_MULT (ENABLE_HW_MULT),
        .ENABLE_HW_DIV  (ENABLE_HW_DIV)
    ) ctrl_decoder_i (
        .head           (head),
        .ctrl_next      (ctrl_next)
    );

    ctrl_issue #(
        .OUT_CREDITS    (OUT_CREDITS)
    ) ctrl_issue_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .not_empty      (not_empty),
        .ctrl_next      (ctrl_next),
        .ctrl_credit    (ctrl_credit),
        .pop            (pop),
        .ctrl_valid     (ctrl_valid),
        .ctrl           (ctrl)
    );

endmodule

//--- hdl/instr_queue.sv
module instr_queue import decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   instr_valid,                  // Write strobe from fetch
    input  instr_u instr,
    input  logic   pop,
    output instr_u head,                         // Oldest entry
    output logic   not_empty,
    output logic   instr_credit                  // One credit back per pop
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    instr_u           mem [QUEUE_DEPTH];          // Entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                     // Occupancy
    logic             full;

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == (PTR_W + 1)'(QUEUE_DEPTH));

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            mem[wr_ptr] <= instr;
        end
    end

    // ------------------------------------------------------------------------
    // Pointers, occupancy and credit return
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            instr_credit <= 1'b0;
        end else begin
            if (instr_valid) begin
                // Wrap at depth, which need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count        <= count + (PTR_W + 1)'(instr_valid) - (PTR_W + 1)'(pop);
            instr_credit <= pop;                 // Slot freed at this edge
        end
    end

    // Fetch must hold off once its credits are spent
    assert property (@(posedge clk) disable iff (!rst_n) !(instr_valid && full))
        else $error("instr_queue: write while full");

    // Issue side may only pop a valid head
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> not_empty)
        else $error("instr_queue: pop while empty");

endmodule

//--- run.sh
#!/bin/sh
# Verilator build and run of the decode unit testbench
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert -j 0 --top-module tb_decode_unit -f files.f > build.log 2>&1 \
    && ./obj_dir/Vtb_decode_unit > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

//--- sim/tb_decode_unit.sv
module tb_decode_unit import decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 100;
    localparam int QUEUE_DEPTH     = 4;
    localparam int OUT_CREDITS     = 2;
    localparam int N_RANDOM        = 200;
    localparam int N_TOTAL         = 64 + 64 + 32 + N_RANDOM;   // Funct, opcode, rt sweeps
    localparam int IDLE_CYCLES     = 6;                         // Quiet time after reset
    localparam int STALL_START     = 100;                       // Execute stall window
    localparam int STALL_LEN       = 40;
    localparam int DRAIN           = 8;
    localparam int WATCHDOG_CYCLES = N_TOTAL * 12 + STALL_LEN + 200;

    logic   clk;
    logic   rst_n;
    logic   instr_valid;
    instr_u instr;
    logic   ctrl_credit;
    logic   instr_credit;
    logic   ctrl_valid;
    ctrl_t  ctrl;
    logic   instr_credit_nm;                     // Instance without mult/div
    logic   ctrl_valid_nm;
    ctrl_t  ctrl_nm;

    int          seed = 99;
    int          assert_errors = 0;
    int          check_errors = 0;
    logic [31:0] stim_q [$];                     // Words in send order
    logic [31:0] sb_q [$];                       // Sent, not yet issued
    ctrl_t       exp_ctrl;
    ctrl_t       exp_ctrl_nm;
    int          fetch_credits;
    int          exec_held;                      // Words at execute, credit not returned
    int          sent_count;
    int          recv_count;
    int          cycle;
    bit          sent_any;

    decode_unit #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .OUT_CREDITS    (OUT_CREDITS),
        .ENABLE_HW_MULT (1),
        .ENABLE_HW_DIV  (1)
    ) decode_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_credit   (instr_credit),
        .ctrl_valid     (ctrl_valid),
        .ctrl           (ctrl),
        .ctrl_credit    (ctrl_credit)
    );

    decode_unit #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .OUT_CREDITS    (OUT_CREDITS),
        .ENABLE_HW_MULT (0),
        .ENABLE_HW_DIV  (0)
    ) decode_unit_nomul_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_credit   (instr_credit_nm),
        .ctrl_valid     (ctrl_valid_nm),
        .ctrl           (ctrl_nm),
        .ctrl_credit    (ctrl_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reference decode
    // ------------------------------------------------------------------------
    function automatic ctrl_t make_word(input alu_op_e alu, input port_a_sel_e a,
                                        input port_b_sel_e b, input wa_sel_e wa,
                                        input logic we);
        ctrl_t c;
        c            = '0;
        c.alu_op     = alu;
        c.port_a_sel = a;
        c.port_b_sel = b;
        c.wa_sel     = wa;
        c.gpr_we     = we;
        return c;
    endfunction

    function automatic ctrl_t ref_decode(input logic [31:0] w, input bit mul_en,
                                         input bit div_en);
        ctrl_t      c;
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rt;
        bit         known;
        op    = w[31:26];
        fn    = w[5:0];
        rt    = w[20:16];
        c     = '0;
        known = 1'b1;
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_ADD:   c = make_word(ALU_ADD,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_ADDU:  c = make_word(ALU_ADDU,  A_RS,    B_RT, WA_RD, 1'b1);
                    FN_SUB:   c = make_word(ALU_SUB,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_SUBU:  c = make_word(ALU_SUBU,  A_RS,    B_RT, WA_RD, 1'b1);
                    FN_AND:   c = make_word(ALU_AND,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_OR:    c = make_word(ALU_OR,    A_RS,    B_RT, WA_RD, 1'b1);
                    FN_XOR:   c = make_word(ALU_XOR,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_NOR:   c = make_word(ALU_NOR,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_SLT:   c = make_word(ALU_SLT,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_SLTU:  c = make_word(ALU_SLTU,  A_RS,    B_RT, WA_RD, 1'b1);
                    FN_SLL:   c = make_word(ALU_SLL,   A_SHAMT, B_RT, WA_RD, 1'b1);
                    FN_SRL:   c = make_word(ALU_SRL,   A_SHAMT, B_RT, WA_RD, 1'b1);
                    FN_SRA:   c = make_word(ALU_SRA,   A_SHAMT, B_RT, WA_RD, 1'b1);
                    FN_SLLV:  c = make_word(ALU_SLL,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_SRLV:  c = make_word(ALU_SRL,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_SRAV:  c = make_word(ALU_SRA,   A_RS,    B_RT, WA_RD, 1'b1);
                    FN_MULT:  c = make_word(ALU_MULT,  A_RS,    B_RT, WA_RD, 1'b0);
                    FN_MULTU: c = make_word(ALU_MULTU, A_RS,    B_RT, WA_RD, 1'b0);
                    FN_DIV:   c = make_word(ALU_DIV,   A_RS,    B_RT, WA_RD, 1'b0);
                    FN_DIVU:  c = make_word(ALU_DIVU,  A_RS,    B_RT, WA_RD, 1'b0);
                    FN_MTHI:  c = make_word(ALU_MTHI,  A_RS,    B_RT, WA_RD, 1'b0);
                    FN_MTLO:  c = make_word(ALU_MTLO,  A_RS,    B_RT, WA_RD, 1'b0);
                    FN_MFHI:  c = make_word(ALU_MFHI,  A_RS,    B_RT, WA_RD, 1'b1);
                    FN_MFLO:  c = make_word(ALU_MFLO,  A_RS,    B_RT, WA_RD, 1'b1);
                    FN_JR:    c = make_word(ALU_NONE,  A_RS,    B_RT, WA_RD, 1'b0);
                    FN_JALR:  c = make_word(ALU_ADDU,  A_PC, B_PC_ADD4, WA_RD, 1'b1);
                    default:  known = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                c     = make_word(ALU_SUB, A_RS, B_RT, WA_RD, 1'b0);
                known = rt inside {RI_BLTZ, RI_BGEZ};       // Linking forms dropped
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: c = make_word(ALU_SUB, A_RS, B_RT, WA_RD, 1'b0);
            OP_J:     c = make_word(ALU_NONE, A_RS, B_RT, WA_RD, 1'b0);
            OP_JAL:   c = make_word(ALU_ADDU, A_PC, B_PC_ADD4, WA_R31, 1'b1);
            OP_ADDI:  c = make_word(ALU_ADD,  A_RS, B_SIMM, WA_RT, 1'b1);
            OP_ADDIU: c = make_word(ALU_ADDU, A_RS, B_SIMM, WA_RT, 1'b1);
            OP_SLTI:  c = make_word(ALU_SLT,  A_RS, B_SIMM, WA_RT, 1'b1);
            OP_SLTIU: c = make_word(ALU_SLTU, A_RS, B_SIMM, WA_RT, 1'b1);
            OP_LUI:   c = make_word(ALU_LUI,  A_RS, B_SIMM, WA_RT, 1'b1);
            OP_ANDI:  c = make_word(ALU_AND,  A_RS, B_ZIMM, WA_RT, 1'b1);
            OP_ORI:   c = make_word(ALU_OR,   A_RS, B_ZIMM, WA_RT, 1'b1);
            OP_XORI:  c = make_word(ALU_XOR,  A_RS, B_ZIMM, WA_RT, 1'b1);
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: c = make_word(ALU_ADDU, A_RS, B_SIMM, WA_RT, 1'b1);
            OP_SB, OP_SH, OP_SW: c = make_word(ALU_ADDU, A_RS, B_SIMM, WA_RD, 1'b0);
            default:  known = 1'b0;
        endcase
        c.branch       = op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM};
        c.jump         = (op inside {OP_J, OP_JAL}) ||
                         (op == OP_SPECIAL && fn inside {FN_JR, FN_JALR});
        c.mem_to_gpr   = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        c.mem_write    = op inside {OP_SB, OP_SH, OP_SW};
        c.mem_byte     = op inside {OP_LB, OP_LBU, OP_SB};
        c.mem_halfword = op inside {OP_LH, OP_LHU, OP_SH};
        c.mem_sign_ext = op inside {OP_LB, OP_LH};
        c.imm_sign_ext = !(op inside {OP_ANDI, OP_ORI, OP_XORI});
        if (!known) begin
            c = '0;
        end
        if (!mul_en && c.alu_op inside {ALU_MULT, ALU_MULTU, ALU_MFHI, ALU_MFLO,
                                        ALU_MTHI, ALU_MTLO}) begin
            c.reserved = 1'b1;
        end
        if (!div_en && c.alu_op inside {ALU_DIV, ALU_DIVU}) begin
            c.reserved = 1'b1;
        end
        return c;
    endfunction

    // ------------------------------------------------------------------------
    // Checks, sampled at the rising edge while outputs are stable
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!rst_n) ctrl_valid |-> ctrl == exp_ctrl)
        else begin
            assert_errors++;
            $display("** Error: ctrl = 0x%h, expected 0x%h", $sampled(ctrl), $sampled(exp_ctrl));
        end

    assert property (@(posedge clk) disable iff (!rst_n) ctrl_valid_nm |-> ctrl_nm == exp_ctrl_nm)
        else begin
            assert_errors++;
            $display("** Error: ctrl_nm = 0x%h, expected 0x%h", $sampled(ctrl_nm),
                     $sampled(exp_ctrl_nm));
        end

    // Both instances share stimulus, so handshakes must line up
    assert property (@(posedge clk) disable iff (!rst_n)
                     ctrl_valid == ctrl_valid_nm && instr_credit == instr_credit_nm)
        else begin
            assert_errors++;
            $display("** Error: ctrl_valid_nm = 0x%h, instr_credit_nm = 0x%h, expected 0x%h, 0x%h",
                     $sampled(ctrl_valid_nm), $sampled(instr_credit_nm),
                     $sampled(ctrl_valid), $sampled(instr_credit));
        end

    assert property (@(posedge clk) disable iff (!rst_n) exec_held <= OUT_CREDITS)
        else begin
            assert_errors++;
            $display("** Error: exec_held = 0x%h, limit 0x%h", $sampled(exec_held), OUT_CREDITS);
        end

    // Returned credits and words in flight both bounded by the queue size
    assert property (@(posedge clk) disable iff (!rst_n)
                     fetch_credits <= QUEUE_DEPTH && sent_count - recv_count <= QUEUE_DEPTH)
        else begin
            assert_errors++;
            $display("** Error: fetch_credits = 0x%h, outstanding = 0x%h, limit 0x%h",
                     $sampled(fetch_credits), $sampled(sent_count - recv_count), QUEUE_DEPTH);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     !sent_any |-> !ctrl_valid && !instr_credit)
        else begin
            assert_errors++;
            $display("** Error: ctrl_valid = 0x%h, instr_credit = 0x%h, expected 0x0 and 0x0",
                     $sampled(ctrl_valid), $sampled(instr_credit));
        end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic build_stimulus();
        logic [31:0] w;
        for (int f = 0; f < 64; f++) begin       // Every SPECIAL funct
            w        = $random(seed);
            w[31:26] = 6'h00;
            w[5:0]   = 6'(f);
            stim_q.push_back(w);
        end
        for (int op = 0; op < 64; op++) begin    // Every primary opcode
            w        = $random(seed);
            w[31:26] = 6'(op);
            stim_q.push_back(w);
        end
        for (int r = 0; r < 32; r++) begin       // Every REGIMM rt code
            w          = $random(seed);
            w[31:26]   = 6'h01;
            w[20:16]   = 5'(r);
            stim_q.push_back(w);
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            w = $random(seed);
            stim_q.push_back(w);
        end
    endtask

    // One cycle of execute and fetch models, driven at the falling edge
    task automatic run_cycle();
        logic [31:0] w;
        @(negedge clk);
        cycle++;
        if (ctrl_valid) begin
            assert (sb_q.size() > 0)
                else begin
                    check_errors++;
                    $display("ctrl_valid with no instruction outstanding at %0t", $time);
                end
            if (sb_q.size() > 0) begin
                w           = sb_q.pop_front();
                exp_ctrl    = ref_decode(w, 1'b1, 1'b1);
                exp_ctrl_nm = ref_decode(w, 1'b0, 1'b0);
            end
            recv_count++;
            exec_held++;
        end
        ctrl_credit = 1'b0;
        if (!(cycle >= STALL_START && cycle < STALL_START + STALL_LEN) && exec_held > 0 &&
            ($random(seed) % 2 != 0)) begin
            ctrl_credit = 1'b1;                  // Random return delay
            exec_held--;
        end
        if (instr_credit) begin
            fetch_credits++;
        end
        instr_valid = 1'b0;
        if (cycle > IDLE_CYCLES && sent_count < N_TOTAL && fetch_credits > 0 &&
            ($random(seed) % 4 != 0)) begin
            instr       = stim_q[sent_count];
            instr_valid = 1'b1;
            fetch_credits--;
            sb_q.push_back(stim_q[sent_count]);
            sent_count++;
            sent_any    = 1'b1;
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        ctrl_credit   = 1'b0;
        exp_ctrl      = '0;
        exp_ctrl_nm   = '0;
        fetch_credits = QUEUE_DEPTH;
        exec_held     = 0;
        sent_count    = 0;
        recv_count    = 0;
        cycle         = 0;
        sent_any      = 1'b0;
        build_stimulus();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        while (recv_count < N_TOTAL) begin
            run_cycle();
        end
        repeat (DRAIN) run_cycle();              // Catch late or extra issues

        assert (recv_count == sent_count)
            else begin
                check_errors++;
                $display("** Error: recv_count = 0x%h, expected 0x%h", recv_count, sent_count);
            end
        assert (sb_q.size() == 0)
            else begin
                check_errors++;
                $display("%0d sent instructions were never issued", sb_q.size());
            end

        $display("Errors: %0d assertion, %0d end of run; %0d sent, %0d issued",
                 assert_errors, check_errors, sent_count, recv_count);
        if (assert_errors == 0 && check_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog sized from the instruction count and the stall window
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired with %0d of %0d instructions issued", recv_count, N_TOTAL);
        $display("Some tests failed");
        $finish;
    end

endmodule
